// File: hdl/vp_timing_pkg.sv
// Videopac front end timing package, clock dividers and cartridge geometry
`default_nettype none

package vp_timing_pkg;

	//////////////////////////////////////////////////////////////////////
	// Clock enable dividers
	//////////////////////////////////////////////////////////////////////

	localparam int DIV_CNT_W = 4;

	// NTSC runs the CPU at sys/8 and the VDC at sys/6
	localparam logic [DIV_CNT_W-1:0] CPU_DIV_NTSC = 4'd8;
	localparam logic [DIV_CNT_W-1:0] CPU_DIV_PAL  = 4'd12;  // PAL sys clock is faster
	localparam logic [DIV_CNT_W-1:0] VDC_DIV_NTSC = 4'd6;
	localparam logic [DIV_CNT_W-1:0] VDC_DIV_PAL  = 4'd10;

	//////////////////////////////////////////////////////////////////////
	// Cartridge and ROM
	//////////////////////////////////////////////////////////////////////

	localparam int CART_ADDR_W = 12;  // Console side address bus
	localparam int ROM_ADDR_W  = 14;  // Up to 16K of image
	localparam int SIZE_CNT_W  = 16;

	// Image sizes recognised by the mapper
	localparam logic [SIZE_CNT_W-1:0] CART_4K  = 16'd4096;
	localparam logic [SIZE_CNT_W-1:0] CART_8K  = 16'd8192;
	localparam logic [SIZE_CNT_W-1:0] CART_16K = 16'd16384;

	// Download slot that carries an XROM image
	localparam logic [7:0] XROM_INDEX = 8'd2;

endpackage

`default_nettype wire

// File: hdl/vp_input_pkg.sv
// Videopac front end input package, pad layout, PS/2 key word and key codes
`default_nettype none

package vp_input_pkg;

	//////////////////////////////////////////////////////////////////////
	// Gamepad word
	//////////////////////////////////////////////////////////////////////

	localparam int PAD_W = 16;

	// Bit positions, 1 when pressed
	localparam int PAD_RIGHT  = 0;
	localparam int PAD_LEFT   = 1;
	localparam int PAD_DOWN   = 2;
	localparam int PAD_UP     = 3;
	localparam int PAD_ACTION = 4;
	localparam int PAD_RESET  = 5;

	// Numpad keys 1..9,0 above the buttons
	localparam int NUMPAD_LSB = 6;
	localparam int NUMPAD_W   = 10;

	localparam int PLAYERS         = 2;
	localparam int PAD_SYNC_STAGES = 2;

	//////////////////////////////////////////////////////////////////////
	// PS/2 key word
	//////////////////////////////////////////////////////////////////////

	localparam int PS2_W       = 11;
	localparam int PS2_TOGGLE  = 10;  // Flips once per event
	localparam int PS2_PRESSED = 9;   // 1 on make, 0 on break
	localparam int PS2_CODE_W  = 8;   // Bit 8 (extended) not used

	//////////////////////////////////////////////////////////////////////
	// Key stream codes
	//////////////////////////////////////////////////////////////////////

	localparam int ASCII_W = 8;

	localparam logic [ASCII_W-1:0] KEY_YES       = 8'h11;
	localparam logic [ASCII_W-1:0] KEY_NO        = 8'h12;
	localparam logic [ASCII_W-1:0] KEY_ENTER     = 8'd10;
	localparam logic [ASCII_W-1:0] KEY_BACKSPACE = 8'd8;
	localparam logic [ASCII_W-1:0] KEY_NONE      = 8'd0;

endpackage

`default_nettype wire

// File: hdl/vp_clock_enables.sv
// CPU and VDC clock enable pulse generator for NTSC or PAL timing
`default_nettype none

module vp_clock_enables
	import vp_timing_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	logic [DIV_CNT_W-1:0] cpu_cnt;
	logic [DIV_CNT_W-1:0] vdc_cnt;
	logic [DIV_CNT_W-1:0] cpu_last;
	logic [DIV_CNT_W-1:0] vdc_last;

	// Terminal counts, mode only changes under reset
	assign cpu_last = pal_i ? CPU_DIV_PAL - DIV_CNT_W'(1) : CPU_DIV_NTSC - DIV_CNT_W'(1);
	assign vdc_last = pal_i ? VDC_DIV_PAL - DIV_CNT_W'(1) : VDC_DIV_NTSC - DIV_CNT_W'(1);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= '0;
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			// CPU divider
			if (cpu_cnt >= cpu_last) begin
				cpu_cnt  <= '0;
				cpu_en_o <= 1'b1;  // One pulse per wrap
			end else begin
				cpu_cnt  <= cpu_cnt + DIV_CNT_W'(1);
				cpu_en_o <= 1'b0;
			end

			// VDC divider
			if (vdc_cnt >= vdc_last) begin
				vdc_cnt  <= '0;
				vdc_en_o <= 1'b1;
			end else begin
				vdc_cnt  <= vdc_cnt + DIV_CNT_W'(1);
				vdc_en_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/vp_cart_mapper.sv
// Cartridge mapper, tracks download size and XROM flag and builds the ROM address
`default_nettype none

module vp_cart_mapper
	import vp_timing_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_download_i,
	input  logic                   ioctl_wr_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic [CART_ADDR_W-1:0] cart_addr_i,
	input  logic                   cart_bank0_i,
	input  logic                   cart_bank1_i,
	output logic [ROM_ADDR_W-1:0]  rom_addr_o
);

	logic                  download_q;
	logic                  download_start;
	logic [SIZE_CNT_W-1:0] cart_size;
	logic                  xrom;

	assign download_start = ioctl_download_i & ~download_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_q <= 1'b0;
		end else begin
			download_q <= ioctl_download_i;
		end
	end

	// Image size and type, kept until the next download
	always_ff @(posedge clk_sys) begin
		if (download_start) begin
			cart_size <= '0;
			xrom      <= (ioctl_index_i == XROM_INDEX);
		end else if (ioctl_download_i && ioctl_wr_i) begin
			cart_size <= cart_size + SIZE_CNT_W'(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address mapping, A10 is skipped on banked images
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (xrom) begin
			rom_addr_o = ROM_ADDR_W'(cart_addr_i);  // Linear 4K view
		end else begin
			case (cart_size)
				CART_4K:  rom_addr_o = ROM_ADDR_W'({cart_bank0_i, cart_addr_i[11],
					cart_addr_i[9:0]});
				CART_8K:  rom_addr_o = ROM_ADDR_W'({cart_bank1_i, cart_bank0_i,
					cart_addr_i[11], cart_addr_i[9:0]});
				CART_16K: rom_addr_o = {cart_bank1_i, cart_bank0_i, cart_addr_i};
				default:  rom_addr_o = ROM_ADDR_W'({cart_addr_i[11], cart_addr_i[9:0]});
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/vp_pad_router.sv
// Gamepad router, applies the player swap and synchronises both pad words
`default_nettype none

module vp_pad_router
	import vp_input_pkg::*;
(
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             swap_i,
	input  logic [PAD_W-1:0] pad_a_i,
	input  logic [PAD_W-1:0] pad_b_i,
	output logic [PAD_W-1:0] pad_o [PLAYERS]
);

	logic [PAD_W-1:0] pad_sel [PLAYERS];
	logic [PAD_W-1:0] sync_q  [PLAYERS][PAD_SYNC_STAGES];

	// Player 0 is pad A unless swapped
	assign pad_sel[0] = swap_i ? pad_b_i : pad_a_i;
	assign pad_sel[1] = swap_i ? pad_a_i : pad_b_i;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < PLAYERS; p++) begin
				for (int s = 0; s < PAD_SYNC_STAGES; s++) begin
					sync_q[p][s] <= '0;  // Nothing pressed
				end
			end
		end else begin
			for (int p = 0; p < PLAYERS; p++) begin
				sync_q[p][0] <= pad_sel[p];
				for (int s = 1; s < PAD_SYNC_STAGES; s++) begin
					sync_q[p][s] <= sync_q[p][s-1];
				end
			end
		end
	end

	always_comb begin
		for (int p = 0; p < PLAYERS; p++) begin
			pad_o[p] = sync_q[p][PAD_SYNC_STAGES-1];
		end
	end

endmodule

`default_nettype wire

// File: hdl/vp_pad_port.sv
// Per-player pad port, active-low directions, numpad change detect and digit encode
`default_nettype none

module vp_pad_port
	import vp_input_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [PAD_W-1:0]   pad_i,
	output logic               up_n_o,
	output logic               down_n_o,
	output logic               left_n_o,
	output logic               right_n_o,
	output logic               action_n_o,
	output logic               reset_pressed_o,
	output logic               numpad_changed_o,
	output logic               numpad_idle_o,
	output logic [ASCII_W-1:0] digit_o
);

	logic [NUMPAD_W-1:0] numpad;
	logic [NUMPAD_W-1:0] numpad_q;
	logic [ASCII_W-1:0]  digit_next;
	logic [ASCII_W-1:0]  digit_q;
	logic                changed_q;

	assign numpad = pad_i[NUMPAD_LSB +: NUMPAD_W];

	// Console expects low when pressed
	assign up_n_o          = ~pad_i[PAD_UP];
	assign down_n_o        = ~pad_i[PAD_DOWN];
	assign left_n_o        = ~pad_i[PAD_LEFT];
	assign right_n_o       = ~pad_i[PAD_RIGHT];
	assign action_n_o      = ~pad_i[PAD_ACTION];
	assign reset_pressed_o = pad_i[PAD_RESET];

	// Lowest numpad bit wins, last bit is the zero key
	always_comb begin
		digit_next = KEY_NONE;
		for (int i = NUMPAD_W - 1; i >= 0; i--) begin
			if (numpad[i]) begin
				digit_next = (i == NUMPAD_W - 1) ? "0" : ASCII_W'(8'h31 + i);
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			numpad_q  <= '0;
			changed_q <= 1'b0;
		end else begin
			numpad_q  <= numpad;
			changed_q <= |(numpad ^ numpad_q);  // Press or release
		end
	end

	// Digit held through the release
	always_ff @(posedge clk_sys) begin
		if (|numpad) begin
			digit_q <= digit_next;
		end
	end

	assign numpad_changed_o = changed_q;
	assign numpad_idle_o    = ~|numpad_q;
	assign digit_o          = digit_q;

endmodule

`default_nettype wire

// File: hdl/vp_key_merger.sv
// Key merger, decodes PS/2 scancodes and merges them with pad digits into one stream
`default_nettype none

module vp_key_merger
	import vp_input_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [PS2_W-1:0]   ps2_key_i,
	input  logic [PLAYERS-1:0] pad_changed_i,
	input  logic [PLAYERS-1:0] pad_idle_i,
	input  logic [PLAYERS-1:0] pad_reset_i,
	input  logic [ASCII_W-1:0] pad_digit_i [PLAYERS],
	output logic               rx_valid_o,
	output logic               rx_released_o,
	output logic               console_res_n_o,
	output logic [ASCII_W-1:0] rx_ascii_o
);

	logic               toggle_q;
	logic               ps2_event;
	logic               ps2_changed_q;
	logic               ps2_released_q;
	logic [ASCII_W-1:0] ps2_ascii_q;
	logic [ASCII_W-1:0] pad_ascii;

	function automatic logic [ASCII_W-1:0] scan_to_ascii(input logic [PS2_CODE_W-1:0] code);
		case (code)
			8'h16: scan_to_ascii = "1";
			8'h1E: scan_to_ascii = "2";
			8'h26: scan_to_ascii = "3";
			8'h25: scan_to_ascii = "4";
			8'h2E: scan_to_ascii = "5";
			8'h36: scan_to_ascii = "6";
			8'h3D: scan_to_ascii = "7";
			8'h3E: scan_to_ascii = "8";
			8'h46: scan_to_ascii = "9";
			8'h45: scan_to_ascii = "0";
			8'h1C: scan_to_ascii = "a";
			8'h32: scan_to_ascii = "b";
			8'h21: scan_to_ascii = "c";
			8'h23: scan_to_ascii = "d";
			8'h24: scan_to_ascii = "e";
			8'h2B: scan_to_ascii = "f";
			8'h34: scan_to_ascii = "g";
			8'h33: scan_to_ascii = "h";
			8'h43: scan_to_ascii = "i";
			8'h3B: scan_to_ascii = "j";
			8'h42: scan_to_ascii = "k";
			8'h4B: scan_to_ascii = "l";
			8'h3A: scan_to_ascii = "m";
			8'h31: scan_to_ascii = "n";
			8'h44: scan_to_ascii = "o";
			8'h4D: scan_to_ascii = "p";
			8'h15: scan_to_ascii = "q";
			8'h2D: scan_to_ascii = "r";
			8'h1B: scan_to_ascii = "s";
			8'h2C: scan_to_ascii = "t";
			8'h3C: scan_to_ascii = "u";
			8'h2A: scan_to_ascii = "v";
			8'h1D: scan_to_ascii = "w";
			8'h22: scan_to_ascii = "x";
			8'h35: scan_to_ascii = "y";
			8'h1A: scan_to_ascii = "z";
			8'h29: scan_to_ascii = " ";
			8'h79: scan_to_ascii = "+";  // Keypad
			8'h7B: scan_to_ascii = "-";
			8'h7C: scan_to_ascii = "*";
			8'h4A: scan_to_ascii = "/";
			8'h55: scan_to_ascii = "=";
			8'h1F: scan_to_ascii = KEY_YES;  // Left GUI
			8'h27: scan_to_ascii = KEY_NO;   // Right GUI
			8'h5A: scan_to_ascii = KEY_ENTER;
			8'h66: scan_to_ascii = KEY_BACKSPACE;
			default: scan_to_ascii = KEY_NONE;
		endcase
	endfunction

	assign ps2_event = (ps2_key_i[PS2_TOGGLE] != toggle_q);

	// Player 0 overrides the others
	always_comb begin
		pad_ascii = KEY_NONE;
		for (int p = PLAYERS - 1; p >= 0; p--) begin
			if (pad_changed_i[p]) begin
				pad_ascii = pad_digit_i[p];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Event stage and output stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q        <= 1'b0;
			ps2_changed_q   <= 1'b0;
			ps2_released_q  <= 1'b1;
			rx_valid_o      <= 1'b0;
			rx_released_o   <= 1'b1;
			console_res_n_o <= 1'b0;  // Console held in reset
		end else begin
			toggle_q        <= ps2_key_i[PS2_TOGGLE];
			ps2_changed_q   <= ps2_event;
			ps2_released_q  <= ~ps2_key_i[PS2_PRESSED];
			rx_valid_o      <= ps2_changed_q | (|pad_changed_i);
			rx_released_o   <= ps2_released_q & (&pad_idle_i);
			console_res_n_o <= ~|pad_reset_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ps2_event) begin
			ps2_ascii_q <= scan_to_ascii(ps2_key_i[PS2_CODE_W-1:0]);
		end
		if (ps2_changed_q) begin
			rx_ascii_o <= ps2_ascii_q;  // Keyboard first
		end else if (|pad_changed_i) begin
			rx_ascii_o <= pad_ascii;
		end
	end

endmodule

`default_nettype wire

// File: hdl/vp_frontend_top.sv
// Videopac front end top, clock enables, pad handling, key stream and cartridge mapping
`default_nettype none

module vp_frontend_top
	import vp_timing_pkg::*;
	import vp_input_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   pal_i,
	input  logic                   swap_i,
	input  logic [PAD_W-1:0]       pad_a_i,
	input  logic [PAD_W-1:0]       pad_b_i,
	input  logic [PS2_W-1:0]       ps2_key_i,
	input  logic                   ioctl_download_i,
	input  logic                   ioctl_wr_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic [CART_ADDR_W-1:0] cart_addr_i,
	input  logic                   cart_bank0_i,
	input  logic                   cart_bank1_i,
	output logic                   cpu_en_o,
	output logic                   vdc_en_o,
	output logic [PLAYERS-1:0]     joy_up_n_o,
	output logic [PLAYERS-1:0]     joy_down_n_o,
	output logic [PLAYERS-1:0]     joy_left_n_o,
	output logic [PLAYERS-1:0]     joy_right_n_o,
	output logic [PLAYERS-1:0]     joy_action_n_o,
	output logic                   rx_valid_o,
	output logic [ASCII_W-1:0]     rx_ascii_o,
	output logic                   rx_released_o,
	output logic                   console_res_n_o,
	output logic [ROM_ADDR_W-1:0]  rom_addr_o
);

	logic [PAD_W-1:0]   pad_sync  [PLAYERS];
	logic [ASCII_W-1:0] pad_digit [PLAYERS];
	logic [PLAYERS-1:0] pad_changed;
	logic [PLAYERS-1:0] pad_idle;
	logic [PLAYERS-1:0] pad_reset;

	vp_clock_enables vp_clock_enables_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	vp_cart_mapper vp_cart_mapper_inst (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.cart_addr_i      (cart_addr_i),
		.cart_bank0_i     (cart_bank0_i),
		.cart_bank1_i     (cart_bank1_i),
		.rom_addr_o       (rom_addr_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Pads, player 0 lands on joystick bit 1
	//////////////////////////////////////////////////////////////////////

	vp_pad_router vp_pad_router_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.swap_i  (swap_i),
		.pad_a_i (pad_a_i),
		.pad_b_i (pad_b_i),
		.pad_o   (pad_sync)
	);

	for (genvar p = 0; p < PLAYERS; p++) begin : gen_pad
		vp_pad_port vp_pad_port_inst (
			.clk_sys          (clk_sys),
			.reset            (reset),
			.pad_i            (pad_sync[p]),
			.up_n_o           (joy_up_n_o[PLAYERS-1-p]),
			.down_n_o         (joy_down_n_o[PLAYERS-1-p]),
			.left_n_o         (joy_left_n_o[PLAYERS-1-p]),
			.right_n_o        (joy_right_n_o[PLAYERS-1-p]),
			.action_n_o       (joy_action_n_o[PLAYERS-1-p]),
			.reset_pressed_o  (pad_reset[p]),
			.numpad_changed_o (pad_changed[p]),
			.numpad_idle_o    (pad_idle[p]),
			.digit_o          (pad_digit[p])
		);
	end

	vp_key_merger vp_key_merger_inst (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ps2_key_i       (ps2_key_i),
		.pad_changed_i   (pad_changed),
		.pad_idle_i      (pad_idle),
		.pad_reset_i     (pad_reset),
		.pad_digit_i     (pad_digit),
		.rx_valid_o      (rx_valid_o),
		.rx_released_o   (rx_released_o),
		.console_res_n_o (console_res_n_o),
		.rx_ascii_o      (rx_ascii_o)
	);

endmodule

`default_nettype wire

// File: test/vp_frontend_properties.sv
// Concurrent checks on the front end enable pulses, key strobe and console reset
`default_nettype none

module vp_frontend_properties (
	input logic clk_sys,
	input logic reset,
	input logic cpu_en_o,
	input logic vdc_en_o,
	input logic rx_valid_o,
	input logic console_res_n_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// Enables are single-cycle pulses
	cpu_en_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o |=> !cpu_en_o)
		else $error("cpu_en_o high on two cycles in a row");

	vdc_en_single: assert property (@(posedge clk_sys) disable iff (reset)
		vdc_en_o |=> !vdc_en_o)
		else $error("vdc_en_o high on two cycles in a row");

	rx_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		rx_valid_o |=> !rx_valid_o)
		else $error("rx_valid_o high on two cycles in a row");

	// Console held while the front end is reset
	res_n_in_reset: assert property (@(posedge clk_sys) reset |-> !console_res_n_o)
		else $error("console_res_n_o high during reset");

endmodule

bind vp_frontend_top vp_frontend_properties vp_frontend_properties_inst (
	.clk_sys         (clk_sys),
	.reset           (reset),
	.cpu_en_o        (cpu_en_o),
	.vdc_en_o        (vdc_en_o),
	.rx_valid_o      (rx_valid_o),
	.console_res_n_o (console_res_n_o)
);

`default_nettype wire

// File: test/vp_frontend_tb.sv
// Videopac front end testbench, table-driven checks of enables, keys, pads and cartridge mapping
`default_nettype none

module vp_frontend_tb
	import vp_timing_pkg::*;
	import vp_input_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 5;
	localparam int CLOCK_WINDOW = 120;
	localparam int KEY_WINDOW   = 6;   // Longest key latency is 4
	localparam int CART_SAMPLES = 16;
	localparam int MARGIN       = 200;

	// Table row kinds
	localparam int ROW_CLOCK = 0;
	localparam int ROW_PS2   = 1;
	localparam int ROW_PAD   = 2;
	localparam int ROW_DIR   = 3;
	localparam int ROW_CART  = 4;

	// Expected cartridge mappings
	localparam logic [2:0] MAP_XROM  = 3'd0;
	localparam logic [2:0] MAP_4K    = 3'd1;
	localparam logic [2:0] MAP_8K    = 3'd2;
	localparam logic [2:0] MAP_16K   = 3'd3;
	localparam logic [2:0] MAP_OTHER = 3'd4;

	logic                   clk_sys;
	logic                   reset;
	logic                   pal_i;
	logic                   swap_i;
	logic [PAD_W-1:0]       pad_a_i;
	logic [PAD_W-1:0]       pad_b_i;
	logic [PS2_W-1:0]       ps2_key_i;
	logic                   ioctl_download_i;
	logic                   ioctl_wr_i;
	logic [7:0]             ioctl_index_i;
	logic [CART_ADDR_W-1:0] cart_addr_i;
	logic                   cart_bank0_i;
	logic                   cart_bank1_i;
	logic                   cpu_en_o;
	logic                   vdc_en_o;
	logic [PLAYERS-1:0]     joy_up_n_o;
	logic [PLAYERS-1:0]     joy_down_n_o;
	logic [PLAYERS-1:0]     joy_left_n_o;
	logic [PLAYERS-1:0]     joy_right_n_o;
	logic [PLAYERS-1:0]     joy_action_n_o;
	logic                   rx_valid_o;
	logic [ASCII_W-1:0]     rx_ascii_o;
	logic                   rx_released_o;
	logic                   console_res_n_o;
	logic [ROM_ADDR_W-1:0]  rom_addr_o;

	int          row_kind [$];
	logic [31:0] row_stim [$];
	logic [31:0] row_exp  [$];

	int          checks      = 0;
	int          errors      = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] lfsr        = 32'h9beb2696;
	logic        ps2_toggle  = 1'b0;
	logic        last_break  = 1'b1;  // Last PS/2 event was a release

	vp_frontend_top vp_frontend_top_inst (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.pal_i            (pal_i),
		.swap_i           (swap_i),
		.pad_a_i          (pad_a_i),
		.pad_b_i          (pad_b_i),
		.ps2_key_i        (ps2_key_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.cart_addr_i      (cart_addr_i),
		.cart_bank0_i     (cart_bank0_i),
		.cart_bank1_i     (cart_bank1_i),
		.cpu_en_o         (cpu_en_o),
		.vdc_en_o         (vdc_en_o),
		.joy_up_n_o       (joy_up_n_o),
		.joy_down_n_o     (joy_down_n_o),
		.joy_left_n_o     (joy_left_n_o),
		.joy_right_n_o    (joy_right_n_o),
		.joy_action_n_o   (joy_action_n_o),
		.rx_valid_o       (rx_valid_o),
		.rx_ascii_o       (rx_ascii_o),
		.rx_released_o    (rx_released_o),
		.console_res_n_o  (console_res_n_o),
		.rom_addr_o       (rom_addr_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	// Galois LFSR, one step per bit
	function automatic logic next_lfsr_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], next_lfsr_bit()};
		return v;
	endfunction

	// A10 is skipped on the banked layouts
	function automatic logic [13:0] expected_rom_addr(input logic [2:0] mode,
		input logic [11:0] a, input logic b0, input logic b1);
		case (mode)
			MAP_XROM: return {2'b00, a};
			MAP_4K:   return {2'b00, b0, a[11], a[9:0]};
			MAP_8K:   return {1'b0, b1, b0, a[11], a[9:0]};
			MAP_16K:  return {b1, b0, a};
			default:  return {3'b000, a[11], a[9:0]};
		endcase
	endfunction

	function automatic int row_cycles(input int kind, input logic [31:0] stim);
		case (kind)
			ROW_CLOCK: return RESET_CYCLES + CLOCK_WINDOW + 1;
			ROW_PS2:   return KEY_WINDOW;
			ROW_PAD:   return 2 * KEY_WINDOW;
			ROW_DIR:   return 6;
			default:   return int'(stim[15:0]) + CART_SAMPLES + 3;
		endcase
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#DRIVE_DELAY;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic add_row(input int kind, input logic [31:0] stim, input logic [31:0] exp);
		row_kind.push_back(kind);
		row_stim.push_back(stim);
		row_exp.push_back(exp);
	endtask

	task automatic add_clock_row(input logic pal, input logic [7:0] cpu_n,
		input logic [7:0] vdc_n);
		add_row(ROW_CLOCK, 32'(pal), 32'({cpu_n, vdc_n}));
	endtask

	task automatic add_ps2_row(input logic pressed, input logic ext, input logic [7:0] code,
		input logic [7:0] ascii);
		add_row(ROW_PS2, 32'({pressed, ext, code}), 32'(ascii));
	endtask

	task automatic add_pad_row(input logic swap, input logic [9:0] na, input logic [9:0] nb,
		input logic [7:0] digit);
		add_row(ROW_PAD, 32'({swap, na, nb}), 32'(digit));
	endtask

	// Expected word is up, down, left, right, action (2 bits each) and res_n
	task automatic add_dir_row(input logic swap, input logic [5:0] a, input logic [5:0] b,
		input logic [10:0] exp_n);
		add_row(ROW_DIR, 32'({swap, a, b}), 32'(exp_n));
	endtask

	task automatic add_cart_row(input logic [7:0] index, input logic [15:0] size,
		input logic [2:0] mode);
		add_row(ROW_CART, 32'({index, size}), 32'(mode));
	endtask

	task automatic build_table();
		add_clock_row(1'b0, 8'd8, 8'd6);    // NTSC
		add_clock_row(1'b1, 8'd12, 8'd10);  // PAL
		add_ps2_row(1'b1, 1'b0, 8'h16, "1");
		add_ps2_row(1'b0, 1'b0, 8'h16, "1");
		add_ps2_row(1'b1, 1'b0, 8'h1C, "a");
		add_ps2_row(1'b0, 1'b0, 8'h1C, "a");
		add_ps2_row(1'b1, 1'b0, 8'h45, "0");
		add_ps2_row(1'b1, 1'b0, 8'h1A, "z");
		add_ps2_row(1'b1, 1'b0, 8'h3A, "m");
		add_ps2_row(1'b1, 1'b0, 8'h29, " ");
		add_ps2_row(1'b1, 1'b0, 8'h79, "+");
		add_ps2_row(1'b1, 1'b0, 8'h7B, "-");
		add_ps2_row(1'b1, 1'b0, 8'h7C, "*");
		add_ps2_row(1'b1, 1'b1, 8'h4A, "/");
		add_ps2_row(1'b1, 1'b0, 8'h55, "=");
		add_ps2_row(1'b1, 1'b1, 8'h1F, 8'h11);
		add_ps2_row(1'b0, 1'b1, 8'h27, 8'h12);
		add_ps2_row(1'b1, 1'b0, 8'h66, 8'd8);
		add_ps2_row(1'b1, 1'b0, 8'h76, 8'd0);  // Escape is not mapped
		add_ps2_row(1'b0, 1'b0, 8'h5A, 8'd10);
		add_pad_row(1'b0, 10'b0000000001, 10'b0000000000, "1");
		add_pad_row(1'b0, 10'b0000010100, 10'b0000000000, "3");
		add_pad_row(1'b0, 10'b0000000000, 10'b1000000000, "0");
		add_pad_row(1'b0, 10'b0100000000, 10'b0000000010, "9");
		add_pad_row(1'b1, 10'b0100000000, 10'b0000000010, "2");
		add_pad_row(1'b1, 10'b0000100000, 10'b0000000000, "6");
		add_pad_row(1'b0, 10'b1001000000, 10'b0010000000, "7");
		add_pad_row(1'b1, 10'b0000001000, 10'b0000010000, "5");
		add_dir_row(1'b0, 6'b001000, 6'b010001, 11'b01_11_11_10_10_1);
		add_dir_row(1'b1, 6'b001000, 6'b010001, 11'b10_11_11_01_01_1);
		add_dir_row(1'b0, 6'b000110, 6'b100000, 11'b11_01_01_11_11_0);
		add_dir_row(1'b1, 6'b000000, 6'b101010, 11'b01_11_01_11_11_0);
		add_cart_row(8'd0, 16'd4096, MAP_4K);
		add_cart_row(8'd1, 16'd8192, MAP_8K);
		add_cart_row(8'd0, 16'd16384, MAP_16K);
		add_cart_row(8'd0, 16'd5000, MAP_OTHER);
		add_cart_row(8'd2, 16'd4096, MAP_XROM);
		add_cart_row(8'd3, 16'd8192, MAP_8K);   // XROM flag must clear again
	endtask

	//////////////////////////////////////////////////////////////////////
	// Row runners
	//////////////////////////////////////////////////////////////////////

	task automatic apply_reset(input logic pal);
		reset            = 1'b1;
		pal_i            = pal;  // Mode only changes under reset
		swap_i           = 1'b0;
		pad_a_i          = '0;
		pad_b_i          = '0;
		ps2_key_i        = '0;
		ps2_toggle       = 1'b0;
		last_break       = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		wait_cycles(RESET_CYCLES);
		compare_value("cpu_en_o", 32'(cpu_en_o), 32'd0);
		compare_value("vdc_en_o", 32'(vdc_en_o), 32'd0);
		compare_value("rx_valid_o", 32'(rx_valid_o), 32'd0);
		compare_value("console_res_n_o", 32'(console_res_n_o), 32'd0);
		reset = 1'b0;
	endtask

	task automatic run_clock_row(input logic [31:0] stim, input logic [31:0] exp);
		int cpu_n;
		int vdc_n;
		int cpu_first;
		int vdc_first;
		int cpu_count;
		int vdc_count;
		cpu_n     = int'(exp[15:8]);
		vdc_n     = int'(exp[7:0]);
		cpu_first = 0;
		vdc_first = 0;
		cpu_count = 0;
		vdc_count = 0;
		apply_reset(stim[0]);
		for (int c = 1; c <= CLOCK_WINDOW; c++) begin
			wait_cycles(1);
			if (cpu_en_o) begin
				cpu_count++;
				if (cpu_first == 0) cpu_first = c;
			end
			if (vdc_en_o) begin
				vdc_count++;
				if (vdc_first == 0) vdc_first = c;
			end
		end
		compare_value("cpu_en_o first pulse", 32'(cpu_first), 32'(cpu_n));
		compare_value("vdc_en_o first pulse", 32'(vdc_first), 32'(vdc_n));
		compare_value("cpu_en_o pulses", 32'(cpu_count), 32'(CLOCK_WINDOW / cpu_n));
		compare_value("vdc_en_o pulses", 32'(vdc_count), 32'(CLOCK_WINDOW / vdc_n));
	endtask

	// One strobe expected inside the window, at a fixed latency
	task automatic watch_key(input int exp_lat, input logic [7:0] exp_ascii,
		input logic exp_rel);
		int         pulses;
		int         lat;
		logic [7:0] ascii;
		logic       rel;
		pulses = 0;
		lat    = 0;
		ascii  = '0;
		rel    = 1'b0;
		for (int c = 1; c <= KEY_WINDOW; c++) begin
			wait_cycles(1);
			if (rx_valid_o) begin
				pulses++;
				if (pulses == 1) begin
					lat   = c;
					ascii = rx_ascii_o;
					rel   = rx_released_o;
				end
			end
		end
		compare_value("rx_valid_o pulses", 32'(pulses), 32'd1);
		compare_value("rx_valid_o latency", 32'(lat), 32'(exp_lat));
		compare_value("rx_ascii_o", 32'(ascii), 32'(exp_ascii));
		compare_value("rx_released_o", 32'(rel), 32'(exp_rel));
	endtask

	task automatic run_ps2_row(input logic [31:0] stim, input logic [31:0] exp);
		ps2_toggle = ~ps2_toggle;
		ps2_key_i  = {ps2_toggle, stim[9:0]};
		last_break = ~stim[9];
		watch_key(2, exp[7:0], ~stim[9]);
	endtask

	task automatic run_pad_row(input logic [31:0] stim, input logic [31:0] exp);
		swap_i  = stim[20];
		pad_a_i = {stim[19:10], 6'b000000};
		pad_b_i = {stim[9:0], 6'b000000};
		watch_key(4, exp[7:0], 1'b0);  // Held numpad masks the release flag
		pad_a_i = '0;
		pad_b_i = '0;
		watch_key(4, exp[7:0], last_break);
	endtask

	task automatic run_dir_row(input logic [31:0] stim, input logic [31:0] exp);
		swap_i  = stim[12];
		pad_a_i = {10'b0, stim[11:6]};
		pad_b_i = {10'b0, stim[5:0]};
		wait_cycles(2);
		compare_value("joy_up_n_o", 32'(joy_up_n_o), 32'(exp[10:9]));
		compare_value("joy_down_n_o", 32'(joy_down_n_o), 32'(exp[8:7]));
		compare_value("joy_left_n_o", 32'(joy_left_n_o), 32'(exp[6:5]));
		compare_value("joy_right_n_o", 32'(joy_right_n_o), 32'(exp[4:3]));
		compare_value("joy_action_n_o", 32'(joy_action_n_o), 32'(exp[2:1]));
		wait_cycles(1);
		compare_value("console_res_n_o", 32'(console_res_n_o), 32'(exp[0]));
		pad_a_i = '0;
		pad_b_i = '0;
		wait_cycles(3);
		compare_value("console_res_n_o", 32'(console_res_n_o), 32'd1);
	endtask

	task automatic run_cart_row(input logic [31:0] stim, input logic [31:0] exp);
		logic [31:0] r;
		ioctl_index_i    = stim[23:16];
		ioctl_download_i = 1'b1;
		ioctl_wr_i       = 1'b0;
		wait_cycles(1);
		ioctl_wr_i = 1'b1;  // One byte per cycle
		wait_cycles(int'(stim[15:0]));
		ioctl_wr_i       = 1'b0;
		ioctl_download_i = 1'b0;
		wait_cycles(1);
		for (int k = 0; k < CART_SAMPLES; k++) begin
			r            = random_bits(14);
			cart_addr_i  = r[11:0];
			cart_bank0_i = r[12];
			cart_bank1_i = r[13];
			#1;
			compare_value("rom_addr_o", 32'(rom_addr_o),
				32'(expected_rom_addr(exp[2:0], r[11:0], r[12], r[13])));
			wait_cycles(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset            = 1'b1;
		pal_i            = 1'b0;
		swap_i           = 1'b0;
		pad_a_i          = '0;
		pad_b_i          = '0;
		ps2_key_i        = '0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = '0;
		cart_addr_i      = '0;
		cart_bank0_i     = 1'b0;
		cart_bank1_i     = 1'b0;
		build_table();
		cycle_limit = RESET_CYCLES + MARGIN;
		for (int r = 0; r < row_kind.size(); r++) begin
			cycle_limit += row_cycles(row_kind[r], row_stim[r]);
		end
		apply_reset(1'b0);
		for (int r = 0; r < row_kind.size(); r++) begin
			case (row_kind[r])
				ROW_CLOCK: run_clock_row(row_stim[r], row_exp[r]);
				ROW_PS2:   run_ps2_row(row_stim[r], row_exp[r]);
				ROW_PAD:   run_pad_row(row_stim[r], row_exp[r]);
				ROW_DIR:   run_dir_row(row_stim[r], row_exp[r]);
				default:   run_cart_row(row_stim[r], row_exp[r]);
			endcase
		end
		wait_cycles(2);
		$display("Run finished: %0d rows, %0d checks, %0d errors",
			row_kind.size(), checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout, the run did not finish within %0d clock cycles", cycle_limit);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/vp_timing_pkg.sv
hdl/vp_input_pkg.sv
hdl/vp_clock_enables.sv
hdl/vp_cart_mapper.sv
hdl/vp_pad_router.sv
hdl/vp_pad_port.sv
hdl/vp_key_merger.sv
hdl/vp_frontend_top.sv
test/vp_frontend_properties.sv
test/vp_frontend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module vp_frontend_tb \
	-Mdir obj_dir -o vp_frontend_sim

output=$(./obj_dir/vp_frontend_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
